//--- common/access_ctrl_cfg.svh
// access gate configuration
`ifndef ACCESS_CTRL_CFG_SVH
`define ACCESS_CTRL_CFG_SVH

// number of regions, one config word holds exactly four entries
`define PMP_NUM_REGIONS 4

// data and address width of all ports
`define DATA_W 32

// source tag width on host and config ports
`define SRC_W 8

// word indices on the config port, taken from addr[9:2]
`define REG_IDX_CFG 8'd0
// first of the four region bound registers
`define REG_IDX_ADDR0 8'd1
`define REG_IDX_RELEASE 8'd240
`define REG_IDX_DENIED_ADDR 8'd241
`define REG_IDX_DENIED_TYPE 8'd242
`define REG_IDX_STATE 8'd243
`define REG_IDX_INTR_STATE 8'd244
`define REG_IDX_INTR_ENABLE 8'd245

`endif

//--- common/access_ctrl_pkg.sv
// access gate shared types
`default_nettype none
`include "access_ctrl_cfg.svh"

package access_ctrl_pkg;

	// region address matching mode
	typedef enum logic [1:0] {
		PMP_MODE_OFF = 2'd0,
		PMP_MODE_TOR = 2'd1
	} pmp_mode_e;

	// one region entry, read enable in bit 0
	typedef struct packed {
		logic [2:0] rsvd_hi;
		pmp_mode_e mode;
		logic rsvd_lo;
		logic w;
		logic r;
	} pmp_cfg_t;

	// the config word is written as raw data and decoded per region
	typedef union packed {
		logic [`DATA_W-1:0] raw;
		pmp_cfg_t [`PMP_NUM_REGIONS-1:0] entry;
	} pmp_cfg_word_u;

	// blocking gate states
	typedef enum logic [1:0] {
		GATE_IDLE = 2'd0,
		GATE_DENY_RSP = 2'd1,
		GATE_DENY_RSP_RELEASED = 2'd2,
		GATE_BLOCKED = 2'd3
	} gate_state_e;

	// denied access type, same codes as TL opcodes
	typedef enum logic [2:0] {
		ACC_WRITE = 3'd0,
		ACC_READ = 3'd4
	} acc_type_e;

	typedef logic [7:0] reg_idx_t;

endpackage

`default_nettype wire

//--- common/reg_bus_if.sv
// register access bus
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

interface reg_bus_if;
	import access_ctrl_pkg::*;

	// one-cycle access strobe, qualified by the port handshake
	logic req;
	logic write;
	reg_idx_t idx;
	logic [`DATA_W-1:0] wdata;
	// read data and error come back in the same cycle
	logic [`DATA_W-1:0] rdata;
	logic err;

	modport master (
		output req, write, idx, wdata,
		input rdata, err
	);

	modport slave (
		input req, write, idx, wdata,
		output rdata, err
	);

endinterface

`default_nettype wire

//--- gate/pmp_check.sv
// region permission check
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module pmp_check (
	input wire logic [`DATA_W-1:0] req_addr_i,
	input wire logic req_write_i,
	input access_ctrl_pkg::pmp_cfg_word_u cfg_word_i,
	input wire logic [`PMP_NUM_REGIONS-1:0][`DATA_W-1:0] region_addr_i,
	output logic deny_o
);
	import access_ctrl_pkg::*;

	// region bounds hold word addresses, so drop the byte offset
	logic [`DATA_W-1:0] word_addr;
	logic matched;
	logic allow;

	assign word_addr = {2'b00, req_addr_i[`DATA_W-1:2]};

	always_comb begin
		logic [`DATA_W-1:0] lo_bound;
		logic hit;
		pmp_cfg_t entry;
		matched = 1'b0;
		allow = 1'b0;
		// region 0 starts at address zero
		lo_bound = '0;
		for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
			entry = cfg_word_i.entry[i];
			// top of range, previous bound inclusive, own bound exclusive
			hit = (entry.mode == PMP_MODE_TOR) &&
				(word_addr >= lo_bound) && (word_addr < region_addr_i[i]);
			// lowest matching region decides
			if (hit && !matched) begin
				matched = 1'b1;
				allow = req_write_i ? entry.w : entry.r;
			end
			lo_bound = region_addr_i[i];
		end
	end

	// no match falls through to deny
	assign deny_o = !(matched && allow);

endmodule

`default_nettype wire

//--- gate/access_fsm.sv
// host gate state machine
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module access_fsm (
	input wire logic clk,
	input wire logic rst,
	input wire logic host_req_valid_i,
	input wire logic [`SRC_W-1:0] host_req_source_i,
	input wire logic host_rsp_ready_i,
	input wire logic dev_req_ready_i,
	input wire logic dev_rsp_valid_i,
	input wire logic [`DATA_W-1:0] dev_rsp_data_i,
	input wire logic dev_rsp_error_i,
	input wire logic [`SRC_W-1:0] dev_rsp_source_i,
	input wire logic deny_i,
	input wire logic release_i,
	output logic host_req_ready_o,
	output logic host_rsp_valid_o,
	output logic [`DATA_W-1:0] host_rsp_data_o,
	output logic host_rsp_error_o,
	output logic [`SRC_W-1:0] host_rsp_source_o,
	output logic dev_req_valid_o,
	output logic dev_rsp_ready_o,
	output logic deny_o,
	output access_ctrl_pkg::gate_state_e state_o
);
	import access_ctrl_pkg::*;

	gate_state_e state_q;
	gate_state_e state_d;
	// source tag of the denied request, returned with the error
	logic [`SRC_W-1:0] deny_src_q;
	logic idle;
	logic err_rsp;

	assign idle = (state_q == GATE_IDLE);
	// the error response is pending until the host takes it
	assign err_rsp = (state_q == GATE_DENY_RSP) || (state_q == GATE_DENY_RSP_RELEASED);

	// a denied request is taken at once and never forwarded
	assign host_req_ready_o = idle && (deny_i || dev_req_ready_i);
	assign dev_req_valid_o = idle && host_req_valid_i && !deny_i;
	assign deny_o = idle && host_req_valid_i && deny_i;

	// response side, relay from device in idle, error word otherwise
	assign dev_rsp_ready_o = idle && host_rsp_ready_i;
	assign host_rsp_valid_o = idle ? dev_rsp_valid_i : err_rsp;
	assign host_rsp_data_o = idle ? dev_rsp_data_i : '0;
	assign host_rsp_error_o = idle ? dev_rsp_error_i : err_rsp;
	assign host_rsp_source_o = idle ? dev_rsp_source_i : deny_src_q;

	assign state_o = state_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			GATE_IDLE: begin
				if (deny_o) begin
					state_d = GATE_DENY_RSP;
				end
			end
			GATE_DENY_RSP: begin
				// release with the handshake skips the blocked state
				if (host_rsp_ready_i) begin
					state_d = release_i ? GATE_IDLE : GATE_BLOCKED;
				end else if (release_i) begin
					state_d = GATE_DENY_RSP_RELEASED;
				end
			end
			GATE_DENY_RSP_RELEASED: begin
				if (host_rsp_ready_i) begin
					state_d = GATE_IDLE;
				end
			end
			GATE_BLOCKED: begin
				// only the cpu can reopen the host port
				if (release_i) begin
					state_d = GATE_IDLE;
				end
			end
			default: begin
				state_d = GATE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= GATE_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (deny_o) begin
			deny_src_q <= host_req_source_i;
		end
	end

endmodule

`default_nettype wire

//--- csr/csr_port.sv
// config port handshake
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module csr_port (
	input wire logic clk,
	input wire logic rst,
	input wire logic cfg_req_valid_i,
	input wire logic cfg_req_write_i,
	input wire logic [`DATA_W-1:0] cfg_req_addr_i,
	input wire logic [`DATA_W-1:0] cfg_req_wdata_i,
	input wire logic [`SRC_W-1:0] cfg_req_source_i,
	input wire logic cfg_rsp_ready_i,
	output logic cfg_req_ready_o,
	output logic cfg_rsp_valid_o,
	output logic [`DATA_W-1:0] cfg_rsp_data_o,
	output logic cfg_rsp_error_o,
	output logic [`SRC_W-1:0] cfg_rsp_source_o,
	reg_bus_if.master bus
);
	import access_ctrl_pkg::*;

	logic accept;
	logic rsp_done;
	logic rsp_valid_q;
	// held response payload
	logic [`DATA_W-1:0] rsp_data_q;
	logic rsp_err_q;
	logic [`SRC_W-1:0] rsp_src_q;

	// one request in flight, the port stalls while a response waits
	assign cfg_req_ready_o = !rsp_valid_q;
	assign accept = cfg_req_valid_i && cfg_req_ready_o;
	assign rsp_done = rsp_valid_q && cfg_rsp_ready_i;

	// register access happens on the acceptance cycle
	assign bus.req = accept;
	assign bus.write = cfg_req_write_i;
	assign bus.idx = reg_idx_t'(cfg_req_addr_i[9:2]);
	assign bus.wdata = cfg_req_wdata_i;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_done) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			// write acks carry no data
			rsp_data_q <= cfg_req_write_i ? '0 : bus.rdata;
			rsp_err_q <= bus.err;
			rsp_src_q <= cfg_req_source_i;
		end
	end

	assign cfg_rsp_valid_o = rsp_valid_q;
	assign cfg_rsp_data_o = rsp_data_q;
	assign cfg_rsp_error_o = rsp_err_q;
	assign cfg_rsp_source_o = rsp_src_q;

endmodule

`default_nettype wire

//--- csr/pmp_regs.sv
// region and status registers
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module pmp_regs (
	input wire logic clk,
	input wire logic rst,
	input wire logic deny_i,
	input wire logic [`DATA_W-1:0] req_addr_i,
	input wire logic req_write_i,
	input access_ctrl_pkg::gate_state_e state_i,
	output access_ctrl_pkg::pmp_cfg_word_u cfg_word_o,
	output logic [`PMP_NUM_REGIONS-1:0][`DATA_W-1:0] region_addr_o,
	output logic release_o,
	output logic irq_o,
	reg_bus_if.slave bus
);
	import access_ctrl_pkg::*;

	pmp_cfg_word_u cfg_word_q;
	logic [`PMP_NUM_REGIONS-1:0][`DATA_W-1:0] region_q;
	logic [`DATA_W-1:0] denied_addr_q;
	acc_type_e denied_type_q;
	logic intr_state_q;
	logic intr_en_q;
	// write strobes from the decode
	logic wr;
	logic addr_hit;
	logic we_cfg;
	logic [`PMP_NUM_REGIONS-1:0] we_addr;
	logic we_ien;
	logic clr_istate;

	assign wr = bus.req && bus.write;

	always_comb begin
		bus.rdata = '0;
		bus.err = 1'b0;
		addr_hit = 1'b0;
		we_cfg = 1'b0;
		we_addr = '0;
		we_ien = 1'b0;
		clr_istate = 1'b0;
		release_o = 1'b0;
		// region bound registers sit right after the cfg word
		for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
			if (bus.idx == reg_idx_t'(`REG_IDX_ADDR0 + i)) begin
				addr_hit = 1'b1;
				bus.rdata = region_q[i];
				we_addr[i] = wr;
			end
		end
		if (!addr_hit) begin
			case (bus.idx)
				`REG_IDX_CFG: begin
					bus.rdata = cfg_word_q.raw;
					we_cfg = wr;
				end
				`REG_IDX_RELEASE: begin
					// write only, data ignored
					bus.err = !bus.write;
					release_o = wr;
				end
				`REG_IDX_DENIED_ADDR: begin
					bus.err = bus.write;
					bus.rdata = denied_addr_q;
				end
				`REG_IDX_DENIED_TYPE: begin
					bus.err = bus.write;
					bus.rdata[2:0] = denied_type_q;
				end
				`REG_IDX_STATE: begin
					bus.err = bus.write;
					bus.rdata[1:0] = state_i;
				end
				`REG_IDX_INTR_STATE: begin
					// any write clears
					bus.rdata[31] = intr_state_q;
					clr_istate = wr;
				end
				`REG_IDX_INTR_ENABLE: begin
					bus.rdata[31] = intr_en_q;
					we_ien = wr;
				end
				default: begin
					bus.err = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg_word_q <= '0;
			region_q <= '0;
			denied_addr_q <= '0;
			denied_type_q <= ACC_WRITE;
			intr_state_q <= 1'b0;
			intr_en_q <= 1'b0;
		end else begin
			if (we_cfg) begin
				cfg_word_q.raw <= bus.wdata;
			end
			for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
				if (we_addr[i]) begin
					region_q[i] <= bus.wdata;
				end
			end
			// capture the offending request
			if (deny_i) begin
				denied_addr_q <= req_addr_i;
				denied_type_q <= req_write_i ? ACC_WRITE : ACC_READ;
			end
			// a new deny beats a clear in the same cycle
			if (deny_i) begin
				intr_state_q <= 1'b1;
			end else if (clr_istate) begin
				intr_state_q <= 1'b0;
			end
			if (we_ien) begin
				intr_en_q <= bus.wdata[31];
			end
		end
	end

	assign cfg_word_o = cfg_word_q;
	assign region_addr_o = region_q;
	assign irq_o = intr_state_q && intr_en_q;

endmodule

`default_nettype wire

//--- verilog/access_ctrl_top.sv
// access control gate top
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module access_ctrl_top (
	input wire logic clk,
	input wire logic rst,
	// host port, untrusted master
	input wire logic host_req_valid_i,
	output logic host_req_ready_o,
	input wire logic [`DATA_W-1:0] host_req_addr_i,
	input wire logic host_req_write_i,
	input wire logic [`DATA_W-1:0] host_req_wdata_i,
	input wire logic [`SRC_W-1:0] host_req_source_i,
	output logic host_rsp_valid_o,
	input wire logic host_rsp_ready_i,
	output logic [`DATA_W-1:0] host_rsp_data_o,
	output logic host_rsp_error_o,
	output logic [`SRC_W-1:0] host_rsp_source_o,
	// device port
	output logic dev_req_valid_o,
	input wire logic dev_req_ready_i,
	output logic [`DATA_W-1:0] dev_req_addr_o,
	output logic dev_req_write_o,
	output logic [`DATA_W-1:0] dev_req_wdata_o,
	output logic [`SRC_W-1:0] dev_req_source_o,
	input wire logic dev_rsp_valid_i,
	output logic dev_rsp_ready_o,
	input wire logic [`DATA_W-1:0] dev_rsp_data_i,
	input wire logic dev_rsp_error_i,
	input wire logic [`SRC_W-1:0] dev_rsp_source_i,
	// config port, trusted cpu
	input wire logic cfg_req_valid_i,
	output logic cfg_req_ready_o,
	input wire logic [`DATA_W-1:0] cfg_req_addr_i,
	input wire logic cfg_req_write_i,
	input wire logic [`DATA_W-1:0] cfg_req_wdata_i,
	input wire logic [`SRC_W-1:0] cfg_req_source_i,
	output logic cfg_rsp_valid_o,
	input wire logic cfg_rsp_ready_i,
	output logic [`DATA_W-1:0] cfg_rsp_data_o,
	output logic cfg_rsp_error_o,
	output logic [`SRC_W-1:0] cfg_rsp_source_o,
	// level interrupt to the cpu
	output logic irq_o
);

	logic deny;
	logic deny_pulse;
	logic release_pulse;
	access_ctrl_pkg::gate_state_e gate_state;
	access_ctrl_pkg::pmp_cfg_word_u cfg_word;
	logic [`PMP_NUM_REGIONS-1:0][`DATA_W-1:0] region_addr;

	reg_bus_if reg_bus ();

	// request payload goes straight to the device, only valid is gated
	assign dev_req_addr_o = host_req_addr_i;
	assign dev_req_write_o = host_req_write_i;
	assign dev_req_wdata_o = host_req_wdata_i;
	assign dev_req_source_o = host_req_source_i;

	pmp_check i_pmp_check (
		.req_addr_i (host_req_addr_i),
		.req_write_i (host_req_write_i),
		.cfg_word_i (cfg_word),
		.region_addr_i (region_addr),
		.deny_o (deny)
	);

	access_fsm i_access_fsm (
		.clk (clk),
		.rst (rst),
		.host_req_valid_i (host_req_valid_i),
		.host_req_source_i (host_req_source_i),
		.host_rsp_ready_i (host_rsp_ready_i),
		.dev_req_ready_i (dev_req_ready_i),
		.dev_rsp_valid_i (dev_rsp_valid_i),
		.dev_rsp_data_i (dev_rsp_data_i),
		.dev_rsp_error_i (dev_rsp_error_i),
		.dev_rsp_source_i (dev_rsp_source_i),
		.deny_i (deny),
		.release_i (release_pulse),
		.host_req_ready_o (host_req_ready_o),
		.host_rsp_valid_o (host_rsp_valid_o),
		.host_rsp_data_o (host_rsp_data_o),
		.host_rsp_error_o (host_rsp_error_o),
		.host_rsp_source_o (host_rsp_source_o),
		.dev_req_valid_o (dev_req_valid_o),
		.dev_rsp_ready_o (dev_rsp_ready_o),
		.deny_o (deny_pulse),
		.state_o (gate_state)
	);

	csr_port i_csr_port (
		.clk (clk),
		.rst (rst),
		.cfg_req_valid_i (cfg_req_valid_i),
		.cfg_req_write_i (cfg_req_write_i),
		.cfg_req_addr_i (cfg_req_addr_i),
		.cfg_req_wdata_i (cfg_req_wdata_i),
		.cfg_req_source_i (cfg_req_source_i),
		.cfg_rsp_ready_i (cfg_rsp_ready_i),
		.cfg_req_ready_o (cfg_req_ready_o),
		.cfg_rsp_valid_o (cfg_rsp_valid_o),
		.cfg_rsp_data_o (cfg_rsp_data_o),
		.cfg_rsp_error_o (cfg_rsp_error_o),
		.cfg_rsp_source_o (cfg_rsp_source_o),
		.bus (reg_bus)
	);

	pmp_regs i_pmp_regs (
		.clk (clk),
		.rst (rst),
		.deny_i (deny_pulse),
		.req_addr_i (host_req_addr_i),
		.req_write_i (host_req_write_i),
		.state_i (gate_state),
		.cfg_word_o (cfg_word),
		.region_addr_o (region_addr),
		.release_o (release_pulse),
		.irq_o (irq_o),
		.bus (reg_bus)
	);

endmodule

`default_nettype wire

//--- verification/tb_access_ctrl.sv
// access gate testbench
`timescale 1ns/10ps
`default_nettype none
`include "access_ctrl_cfg.svh"

module tb_access_ctrl;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	// random accesses per region in the pass-through test
	localparam int N_PASS_R0 = 16;
	localparam int N_PASS_R1 = 4;
	localparam int CFG_OPS = 30;
	localparam int HOST_OPS = N_PASS_R0 + N_PASS_R1 + 10;
	localparam int OP_CYCLES = 4;
	localparam int HOLD_CYCLES = 4;
	localparam int WAIT_LIMIT = 20;
	// twice the expected run length
	localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
		(RESET_CYCLES + (CFG_OPS + HOST_OPS) * OP_CYCLES + 4 * HOLD_CYCLES);

	// region 0 read and write, region 1 read only, both top of range
	localparam logic [31:0] CFG_WORD = 32'h0000_090b;
	// word address bounds
	// regions 2 and 3 stay off in the cfg word
	localparam logic [3:0][31:0] BOUNDS = {32'h1000, 32'h0c00, 32'h0800, 32'h0400};

	logic clk = 1'b0;
	logic rst;
	logic host_req_valid_i;
	logic host_req_ready_o;
	logic [`DATA_W-1:0] host_req_addr_i;
	logic host_req_write_i;
	logic [`DATA_W-1:0] host_req_wdata_i;
	logic [`SRC_W-1:0] host_req_source_i;
	logic host_rsp_valid_o;
	logic host_rsp_ready_i;
	logic [`DATA_W-1:0] host_rsp_data_o;
	logic host_rsp_error_o;
	logic [`SRC_W-1:0] host_rsp_source_o;
	logic dev_req_valid_o;
	logic dev_req_ready_i;
	logic [`DATA_W-1:0] dev_req_addr_o;
	logic dev_req_write_o;
	logic [`DATA_W-1:0] dev_req_wdata_o;
	logic [`SRC_W-1:0] dev_req_source_o;
	logic dev_rsp_valid_i;
	logic dev_rsp_ready_o;
	logic [`DATA_W-1:0] dev_rsp_data_i;
	logic dev_rsp_error_i;
	logic [`SRC_W-1:0] dev_rsp_source_i;
	logic cfg_req_valid_i;
	logic cfg_req_ready_o;
	logic [`DATA_W-1:0] cfg_req_addr_i;
	logic cfg_req_write_i;
	logic [`DATA_W-1:0] cfg_req_wdata_i;
	logic [`SRC_W-1:0] cfg_req_source_i;
	logic cfg_rsp_valid_o;
	logic cfg_rsp_ready_i;
	logic [`DATA_W-1:0] cfg_rsp_data_o;
	logic cfg_rsp_error_o;
	logic [`SRC_W-1:0] cfg_rsp_source_o;
	logic irq_o;

	integer seed;
	string test_name;
	// running source tag on the config port
	logic [7:0] cfg_src;

	always #(CLK_PERIOD / 2) clk = ~clk;

	access_ctrl_top i_access_ctrl_top (.*);

	task automatic fail_run(input string what);
		$display("ERROR [%s] %s", test_name, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED [%s] %s: expected %h, actual %h",
				test_name, what, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		check_word(what, {31'd0, expected}, {31'd0, actual});
	endtask

	// one config access that returns read data and error
	task automatic cfg_access(input logic write, input logic [7:0] idx,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		logic [7:0] src;
		@(negedge clk);
		src = cfg_src;
		cfg_src = cfg_src + 8'd1;
		cfg_req_valid_i = 1'b1;
		cfg_req_write_i = write;
		cfg_req_addr_i = {22'd0, idx, 2'b00};
		cfg_req_wdata_i = wdata;
		cfg_req_source_i = src;
		#1;
		n = 0;
		while (cfg_req_ready_o !== 1'b1) begin
			@(negedge clk);
			#1;
			n++;
			if (n > WAIT_LIMIT) fail_run("config request was never accepted");
		end
		// taken on the next rising edge
		@(negedge clk);
		cfg_req_valid_i = 1'b0;
		#1;
		n = 0;
		while (cfg_rsp_valid_o !== 1'b1) begin
			@(negedge clk);
			#1;
			n++;
			if (n > WAIT_LIMIT) fail_run("config response never arrived");
		end
		check_word("config response source", 32'(src), 32'(cfg_rsp_source_o));
		rdata = cfg_rsp_data_o;
		err = cfg_rsp_error_o;
	endtask

	task automatic reg_write(input logic [7:0] idx, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		cfg_access(1'b1, idx, data, rd, err);
		check_bit($sformatf("error on write of index %0d", idx), 1'b0, err);
		check_word($sformatf("write data of index %0d", idx), 32'd0, rd);
	endtask

	task automatic reg_read(input logic [7:0] idx, input logic [31:0] expected);
		logic [31:0] rd;
		logic err;
		cfg_access(1'b0, idx, 32'd0, rd, err);
		check_bit($sformatf("error on read of index %0d", idx), 1'b0, err);
		check_word($sformatf("read of index %0d", idx), expected, rd);
	endtask

	task automatic reg_expect_err(input logic write, input logic [7:0] idx);
		logic [31:0] rd;
		logic err;
		cfg_access(write, idx, 32'h1234_5678, rd, err);
		check_bit($sformatf("error flag for index %0d", idx), 1'b1, err);
	endtask

	// permitted request that the device answers one cycle later
	task automatic pass_access(input logic [31:0] addr, input logic write,
		input logic [31:0] wdata, input logic [7:0] src);
		int n;
		logic [31:0] r;
		logic [31:0] rsp_data;
		@(negedge clk);
		dev_req_ready_i = 1'b0;
		host_req_valid_i = 1'b1;
		host_req_addr_i = addr;
		host_req_write_i = write;
		host_req_wdata_i = wdata;
		host_req_source_i = src;
		#1;
		// the device stalls one cycle and the host waits with it
		check_bit("host ready during device stall", 1'b0, host_req_ready_o);
		check_bit("device request valid during stall", 1'b1, dev_req_valid_o);
		@(negedge clk);
		dev_req_ready_i = 1'b1;
		#1;
		n = 0;
		while (host_req_ready_o !== 1'b1) begin
			@(negedge clk);
			#1;
			n++;
			if (n > WAIT_LIMIT) fail_run("host request was never accepted");
		end
		check_bit("device request valid", 1'b1, dev_req_valid_o);
		check_word("device address", addr, dev_req_addr_o);
		check_bit("device write bit", write, dev_req_write_o);
		check_word("device write data", wdata, dev_req_wdata_o);
		check_word("device source", 32'(src), 32'(dev_req_source_o));
		r = $random(seed);
		rsp_data = $random(seed);
		@(negedge clk);
		host_req_valid_i = 1'b0;
		dev_rsp_valid_i = 1'b1;
		dev_rsp_data_i = rsp_data;
		dev_rsp_error_i = r[0];
		dev_rsp_source_i = src;
		#1;
		check_bit("device response ready", 1'b1, dev_rsp_ready_o);
		check_bit("host response valid", 1'b1, host_rsp_valid_o);
		check_word("host response data", rsp_data, host_rsp_data_o);
		check_bit("host response error", r[0], host_rsp_error_o);
		check_word("host response source", 32'(src), 32'(host_rsp_source_o));
		@(negedge clk);
		dev_rsp_valid_i = 1'b0;
	endtask

	task automatic check_err_rsp(input logic [7:0] src);
		check_bit("error response valid", 1'b1, host_rsp_valid_o);
		check_bit("error response flag", 1'b1, host_rsp_error_o);
		check_word("error response data", 32'd0, host_rsp_data_o);
		check_word("error response source", 32'(src), 32'(host_rsp_source_o));
		check_bit("host ready while gated", 1'b0, host_req_ready_o);
		check_bit("device response ready while gated", 1'b0, dev_rsp_ready_o);
	endtask

	// denied request is taken at once and answered with an error from the next cycle
	task automatic deny_request(input logic [31:0] addr, input logic write,
		input logic [7:0] src, input logic rsp_ready);
		@(negedge clk);
		// device not ready, so only the deny path can accept
		dev_req_ready_i = 1'b0;
		host_rsp_ready_i = rsp_ready;
		host_req_valid_i = 1'b1;
		host_req_addr_i = addr;
		host_req_write_i = write;
		host_req_wdata_i = $random(seed);
		host_req_source_i = src;
		#1;
		check_bit("denied request accepted", 1'b1, host_req_ready_o);
		check_bit("denied request kept from device", 1'b0, dev_req_valid_o);
		@(negedge clk);
		host_req_valid_i = 1'b0;
		dev_req_ready_i = 1'b1;
		#1;
		check_err_rsp(src);
	endtask

	// take the error response and raise ready if it was held low
	task automatic finish_err_rsp(input logic [7:0] src);
		if (host_rsp_ready_i !== 1'b1) begin
			@(negedge clk);
			host_rsp_ready_i = 1'b1;
			#1;
			check_err_rsp(src);
		end
		@(negedge clk);
		#1;
		check_bit("error response taken", 1'b0, host_rsp_valid_o);
	endtask

	task automatic test_reset_cfg();
		test_name = "reset_cfg";
		@(negedge clk);
		#1;
		check_bit("irq after reset", 1'b0, irq_o);
		check_bit("host response after reset", 1'b0, host_rsp_valid_o);
		check_bit("device request after reset", 1'b0, dev_req_valid_o);
		check_bit("config response after reset", 1'b0, cfg_rsp_valid_o);
		check_bit("config ready after reset", 1'b1, cfg_req_ready_o);
		reg_read(`REG_IDX_STATE, 32'd0);
		reg_write(`REG_IDX_CFG, CFG_WORD);
		for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
			reg_write(8'(`REG_IDX_ADDR0 + i), BOUNDS[i]);
		end
		reg_read(`REG_IDX_CFG, CFG_WORD);
		for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
			reg_read(8'(`REG_IDX_ADDR0 + i), BOUNDS[i]);
		end
		// unmapped read and read-only write
		reg_expect_err(1'b0, 8'd250);
		reg_expect_err(1'b1, `REG_IDX_DENIED_ADDR);
	endtask

	task automatic test_pass();
		logic [31:0] r;
		logic [31:0] wdata;
		test_name = "pass_through";
		// region 0 covers bytes 0 to 0xfff
		for (int i = 0; i < N_PASS_R0; i++) begin
			r = $random(seed);
			wdata = $random(seed);
			pass_access({20'd0, r[11:2], 2'b00}, r[12], wdata, r[23:16]);
		end
		// region 1 is read only and covers bytes 0x1000 to 0x1fff
		for (int i = 0; i < N_PASS_R1; i++) begin
			r = $random(seed);
			pass_access({19'd0, 1'b1, r[11:2], 2'b00}, 1'b0, 32'd0, r[23:16]);
		end
	endtask

	task automatic test_deny();
		test_name = "deny";
		reg_write(`REG_IDX_INTR_ENABLE, 32'h8000_0000);
		check_bit("irq before deny", 1'b0, irq_o);
		deny_request(32'h0000_1a40, 1'b1, 8'h5a, 1'b1);
		finish_err_rsp(8'h5a);
		check_bit("irq after deny", 1'b1, irq_o);
		reg_read(`REG_IDX_DENIED_ADDR, 32'h0000_1a40);
		reg_read(`REG_IDX_DENIED_TYPE, 32'd0);
		reg_read(`REG_IDX_STATE, 32'd3);
		// a permitted address is still held off while blocked
		@(negedge clk);
		host_req_valid_i = 1'b1;
		host_req_addr_i = 32'h0000_0100;
		host_req_write_i = 1'b0;
		repeat (HOLD_CYCLES) begin
			#1;
			check_bit("host ready while blocked", 1'b0, host_req_ready_o);
			check_bit("device request while blocked", 1'b0, dev_req_valid_o);
			@(negedge clk);
		end
		host_req_valid_i = 1'b0;
		reg_read(`REG_IDX_STATE, 32'd3);
	endtask

	task automatic test_release();
		test_name = "release";
		reg_write(`REG_IDX_RELEASE, 32'd0);
		reg_read(`REG_IDX_STATE, 32'd0);
		pass_access(32'h0000_0100, 1'b1, 32'hcafe_0001, 8'h11);
		check_bit("irq before clear", 1'b1, irq_o);
		reg_write(`REG_IDX_INTR_STATE, 32'd0);
		check_bit("irq after clear", 1'b0, irq_o);
		reg_read(`REG_IDX_INTR_STATE, 32'd0);
		// masked interrupt still records the deny
		reg_write(`REG_IDX_INTR_ENABLE, 32'd0);
		deny_request(32'h0000_1800, 1'b1, 8'h22, 1'b1);
		finish_err_rsp(8'h22);
		check_bit("masked irq", 1'b0, irq_o);
		reg_read(`REG_IDX_INTR_STATE, 32'h8000_0000);
		reg_write(`REG_IDX_RELEASE, 32'd0);
		reg_read(`REG_IDX_STATE, 32'd0);
	endtask

	task automatic test_backpressure();
		test_name = "release_backpressure";
		// outside every region with the host not ready for the response
		deny_request(32'h0000_3000, 1'b0, 8'h3c, 1'b0);
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			#1;
			check_err_rsp(8'h3c);
		end
		reg_write(`REG_IDX_RELEASE, 32'd0);
		check_err_rsp(8'h3c);
		reg_read(`REG_IDX_STATE, 32'd2);
		check_err_rsp(8'h3c);
		finish_err_rsp(8'h3c);
		reg_read(`REG_IDX_STATE, 32'd0);
		reg_read(`REG_IDX_DENIED_ADDR, 32'h0000_3000);
		reg_read(`REG_IDX_DENIED_TYPE, 32'd4);
		pass_access(32'h0000_0ffc, 1'b0, 32'd0, 8'h77);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog timeout, the run did not finish in time");
	end

	initial begin
		seed = 32'h04a3_7482;
		test_name = "init";
		cfg_src = 8'd0;
		rst = 1'b0;
		host_req_valid_i = 1'b0;
		host_req_addr_i = '0;
		host_req_write_i = 1'b0;
		host_req_wdata_i = '0;
		host_req_source_i = '0;
		host_rsp_ready_i = 1'b1;
		// device ready by default and answered by the access tasks
		dev_req_ready_i = 1'b1;
		dev_rsp_valid_i = 1'b0;
		dev_rsp_data_i = '0;
		dev_rsp_error_i = 1'b0;
		dev_rsp_source_i = '0;
		cfg_req_valid_i = 1'b0;
		cfg_req_addr_i = '0;
		cfg_req_write_i = 1'b0;
		cfg_req_wdata_i = '0;
		cfg_req_source_i = '0;
		cfg_rsp_ready_i = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;
		test_reset_cfg();
		test_pass();
		test_deny();
		test_release();
		test_backpressure();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/access_ctrl_pkg.sv
common/reg_bus_if.sv
gate/pmp_check.sv
gate/access_fsm.sv
csr/csr_port.sv
csr/pmp_regs.sv
verilog/access_ctrl_top.sv
verification/tb_access_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the access gate testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f compile.f --top-module tb_access_ctrl -o tb_access_ctrl

# keep the output even when the run stops on a failure
out=$(./obj_dir/tb_access_ctrl) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi
